// File: credit_fifo_top.f
source/credit_fifo_pkg.sv
source/credit_sender.sv
source/fifo_ctrl_credit.sv
source/fifo_flop_ram.sv
source/pop_output_stage.sv
source/credit_fifo_top.sv
tb/credit_fifo_tb.sv

// File: Makefile
# Verilator build of the credit FIFO testbench; "make check" runs it and judges the log

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
obj_dir/Vcredit_fifo_tb: credit_fifo_top.f $(SOURCES)
	verilator --binary --timing -f credit_fifo_top.f --top-module credit_fifo_tb -o Vcredit_fifo_tb

run: obj_dir/Vcredit_fifo_tb
	obj_dir/Vcredit_fifo_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log

check: run
	@grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" || \
	  (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: tb/credit_fifo_tb.sv
// Drives inputs on falling edges and samples mid-cycle; the first mismatch ends the run
`timescale 1ns/1ps

module credit_fifo_tb;

  localparam int num_rows      = 11;
  localparam int clk_period    = 20;
  localparam int reset_cycles  = 5;
  localparam int margin_cycles = 40;
  localparam logic [15:0] lfsr_seed = 16'd25;
  // Marks an expected column that is not checked, and pop_ready drawn from the LFSR
  localparam int dont_care  = 99;
  localparam int pop_random = 2;

  typedef struct packed {
    int src_valid;
    int pop_mode;
    int stall;
    int cycles;
    int exp_ready;
    int exp_len;
  } row_t;

  // Expected src_ready and reference queue length hold just after the row's last edge
  string row_names [num_rows] = '{"idle", "single_push", "latency_idle", "stream",
    "backpressure", "drain_stalled", "stall_release", "stall_stream", "unstall_stream",
    "random_pop", "drain"};
  row_t rows [num_rows] = '{
    '{0, 1, 0,  3, 1, 0},
    '{1, 1, 0,  1, 1, 1},
    '{0, 1, 0,  5, 1, 0},
    '{1, 1, 0, 12, 1, 2},
    '{1, 0, 0,  8, 0, 5},
    '{1, 1, 1,  8, 0, 0},
    '{0, 1, 0,  6, 1, 0},
    '{1, 1, 1, 10, 0, 0},
    '{1, 1, 0, 10, 1, 2},
    '{1, 2, 0, 40, dont_care, dont_care},
    '{0, 1, 0, 12, 1, 0}
  };

  logic clk = 1'b0;
  logic rst;
  logic src_valid;
  logic [credit_fifo_pkg::data_width-1:0] src_data;
  logic src_ready;
  logic credit_stall;
  logic pop_ready;
  logic pop_valid;
  logic [credit_fifo_pkg::data_width-1:0] pop_data;
  logic [credit_fifo_pkg::count_width-1:0] items;
  logic empty;
  logic full;

  // Words taken at the source and not yet popped, oldest first
  logic [credit_fifo_pkg::data_width-1:0] ref_q [$];
  logic [15:0] lfsr_state = lfsr_seed;
  // Cycles left until pop_valid must rise after a push into an idle link
  int latency_left = -1;
  // Words taken since credit_stall last went high
  int stall_taken = 0;

  credit_fifo_top UUT (
    .clk, .rst, .src_valid, .src_data, .src_ready, .credit_stall, .pop_ready,
    .pop_valid, .pop_data, .items, .empty, .full
  );

  always #(clk_period / 2) clk = ~clk;

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------

  // Fibonacci form of x^16 + x^14 + x^13 + x^11 + 1, new bit shifted in at the bottom
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_random_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic random_word(output logic [credit_fifo_pkg::data_width-1:0] w);
    logic b;
    for (int i = 0; i < credit_fifo_pkg::data_width; i++) begin
      next_random_bit(b);
      w[i] = b;
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic drive_row(input int r);
    logic b;
    src_valid    = (rows[r].src_valid != 0);
    credit_stall = (rows[r].stall != 0);
    if (rows[r].pop_mode == pop_random) begin
      next_random_bit(b);
      pop_ready = b;
    end else begin
      pop_ready = (rows[r].pop_mode != 0);
    end
    // A fresh word is offered each cycle the source is valid
    if (src_valid) begin
      random_word(src_data);
    end
  endtask

  // Runs mid-cycle, then moves the reference model past the coming rising edge
  task automatic sample_cycle(input string name);
    bit pushed;
    int ram_words;
    pushed = src_valid && src_ready;
    // Words in the RAM plus the one in the pop register make up the whole queue
    ram_words = ref_q.size() - int'(pop_valid);
    check_value({name, " occupancy"}, ram_words, int'(items));
    check_value({name, " empty"}, (ram_words == 0) ? 1 : 0, int'(empty));
    check_value({name, " full"}, (ram_words == credit_fifo_pkg::fifo_depth) ? 1 : 0,
                int'(full));
    check_value({name, " queue bound"}, 1,
                (ref_q.size() <= credit_fifo_pkg::fifo_depth + 1) ? 1 : 0);
    if (latency_left > 0) begin
      latency_left--;
      check_value({name, " latency"}, (latency_left == 0) ? 1 : 0, int'(pop_valid));
      if (latency_left == 0) begin
        latency_left = -1;
      end
    end
    if (pop_valid) begin
      check_value({name, " pop order"}, int'(ref_q[0]), int'(pop_data));
    end
    if (!credit_stall) begin
      stall_taken = 0;
    end else if (pushed) begin
      stall_taken++;
    end
    check_value({name, " stall credit"}, 1,
                (stall_taken <= credit_fifo_pkg::fifo_depth) ? 1 : 0);
    if (pop_valid && pop_ready) begin
      void'(ref_q.pop_front());
    end
    if (pushed) begin
      if (ref_q.size() == 0 && !pop_valid) begin
        latency_left = 2;
      end
      ref_q.push_back(src_data);
    end
  endtask

  //--------------------------------------------------------------------------
  // Watchdog
  //--------------------------------------------------------------------------

  initial begin : watchdog
    int total;
    total = reset_cycles + margin_cycles;
    for (int r = 0; r < num_rows; r++) begin
      total += rows[r].cycles;
    end
    #(total * clk_period);
    $display("Watchdog expired: the test table did not finish in the expected time");
    $display("CHECKS FAILED");
    $fatal(1, "Run timed out");
  end

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin : main_seq
    rst          = 1'b1;
    src_valid    = 1'b0;
    src_data     = '0;
    credit_stall = 1'b0;
    pop_ready    = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #5;
    // Full credit and an empty link straight out of reset
    check_value("reset src_ready", 1, int'(src_ready));
    check_value("reset empty", 1, int'(empty));
    check_value("reset pop_valid", 0, int'(pop_valid));
    check_value("reset full", 0, int'(full));
    check_value("reset items", 0, int'(items));
    for (int r = 0; r < num_rows; r++) begin
      for (int c = 0; c < rows[r].cycles; c++) begin
        @(negedge clk);
        drive_row(r);
        #5;
        sample_cycle(row_names[r]);
      end
      @(posedge clk);
      #1;
      if (rows[r].exp_ready != dont_care) begin
        check_value({row_names[r], " end src_ready"}, rows[r].exp_ready, int'(src_ready));
      end
      if (rows[r].exp_len != dont_care) begin
        check_value({row_names[r], " end length"}, rows[r].exp_len, ref_q.size());
      end
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : credit_fifo_tb

// File: source/credit_fifo_top.sv
// Holds fifo_depth words in RAM plus one in the pop register; push to pop takes 2 cycles
`timescale 1ns/1ps

module credit_fifo_top (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    src_valid,
  input  logic [credit_fifo_pkg::data_width-1:0]  src_data,
  output logic                                    src_ready,
  input  logic                                    credit_stall,
  input  logic                                    pop_ready,
  output logic                                    pop_valid,
  output logic [credit_fifo_pkg::data_width-1:0]  pop_data,
  output logic [credit_fifo_pkg::count_width-1:0] items,
  output logic                                    empty,
  output logic                                    full
);

  //--------------------------------------------------------------------------
  // Internal links
  //--------------------------------------------------------------------------

  // Sender and controller
  logic                                  push_valid;
  logic [credit_fifo_pkg::data_width-1:0] push_data;
  logic                                  push_credit;

  // Controller and RAM
  logic                                  ram_wr_valid;
  logic [credit_fifo_pkg::addr_width-1:0] ram_wr_addr;
  logic [credit_fifo_pkg::data_width-1:0] ram_wr_data;
  logic [credit_fifo_pkg::addr_width-1:0] ram_rd_addr;
  logic [credit_fifo_pkg::data_width-1:0] ram_rd_data;

  // Controller and output stage
  logic                                  stage_load;
  logic [credit_fifo_pkg::data_width-1:0] stage_data;
  logic                                  stage_ready;

  //--------------------------------------------------------------------------
  // Pipeline
  //--------------------------------------------------------------------------

  credit_sender u_sender (
    .clk, .rst, .src_valid, .src_data, .push_credit, .src_ready, .push_valid, .push_data
  );

  fifo_ctrl_credit u_ctrl (
    .clk, .rst, .push_valid, .push_data, .credit_stall, .stage_ready, .ram_rd_data,
    .push_credit, .ram_wr_valid, .ram_wr_addr, .ram_wr_data, .ram_rd_addr,
    .stage_load, .stage_data, .items, .empty, .full
  );

  fifo_flop_ram u_ram (
    .clk, .ram_wr_valid, .ram_wr_addr, .ram_wr_data, .ram_rd_addr, .ram_rd_data
  );

  pop_output_stage u_pop (
    .clk, .rst, .stage_load, .stage_data, .pop_ready, .stage_ready, .pop_valid, .pop_data
  );

endmodule : credit_fifo_top

// File: source/pop_output_stage.sv
// One-entry register; stage_ready depends combinationally on pop_ready for full-rate flow
`timescale 1ns/1ps

module pop_output_stage (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  stage_load,
  input  logic [credit_fifo_pkg::data_width-1:0] stage_data,
  input  logic                                  pop_ready,
  output logic                                  stage_ready,
  output logic                                  pop_valid,
  output logic [credit_fifo_pkg::data_width-1:0] pop_data
);

  credit_fifo_pkg::out_state_t state;

  // Holds the word presented on the pop side
  logic [credit_fifo_pkg::data_width-1:0] data_q;

  //--------------------------------------------------------------------------
  // Handshake
  //--------------------------------------------------------------------------

  assign pop_valid = (state == credit_fifo_pkg::out_full);
  assign pop_data  = data_q;

  // A new word fits if the register is free or its word leaves this cycle
  assign stage_ready = (state == credit_fifo_pkg::out_empty) || pop_ready;

  //--------------------------------------------------------------------------
  // State and data
  //--------------------------------------------------------------------------

  // A load wins over a pop, which covers the back-to-back case
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= credit_fifo_pkg::out_empty;
    end else if (stage_load) begin
      state <= credit_fifo_pkg::out_full;
    end else if (pop_valid && pop_ready) begin
      state <= credit_fifo_pkg::out_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_load) begin
      data_q <= stage_data;
    end
  end

endmodule : pop_output_stage

// File: source/fifo_flop_ram.sv
// Cells have no reset and the read is combinational; the controller never reads a written slot
`timescale 1ns/1ps

module fifo_flop_ram (
  input  logic                                   clk,
  input  logic                                   ram_wr_valid,
  input  logic [credit_fifo_pkg::addr_width-1:0] ram_wr_addr,
  input  logic [credit_fifo_pkg::data_width-1:0] ram_wr_data,
  input  logic [credit_fifo_pkg::addr_width-1:0] ram_rd_addr,
  output logic [credit_fifo_pkg::data_width-1:0] ram_rd_data
);

  //--------------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------------

  // One register per FIFO entry
  logic [credit_fifo_pkg::data_width-1:0] mem [credit_fifo_pkg::fifo_depth];

  // Write port, a single slot updated at the clock edge
  always_ff @(posedge clk) begin
    if (ram_wr_valid) begin
      mem[ram_wr_addr] <= ram_wr_data;
    end
  end

  //--------------------------------------------------------------------------
  // Read port
  //--------------------------------------------------------------------------

  // Read data follows the address within the same cycle.
  // The controller samples it at the edge where it loads the output stage
  assign ram_rd_data = mem[ram_rd_addr];

endmodule : fifo_flop_ram

// File: source/fifo_ctrl_credit.sv
// No bypass path: a push is seen by the output stage one cycle later; credit return is one cycle
`timescale 1ns/1ps

module fifo_ctrl_credit (
  input  logic                                    clk,
  input  logic                                    rst,
  input  logic                                    push_valid,
  input  logic [credit_fifo_pkg::data_width-1:0]  push_data,
  input  logic                                    credit_stall,
  input  logic                                    stage_ready,
  input  logic [credit_fifo_pkg::data_width-1:0]  ram_rd_data,
  output logic                                    push_credit,
  output logic                                    ram_wr_valid,
  output logic [credit_fifo_pkg::addr_width-1:0]  ram_wr_addr,
  output logic [credit_fifo_pkg::data_width-1:0]  ram_wr_data,
  output logic [credit_fifo_pkg::addr_width-1:0]  ram_rd_addr,
  output logic                                    stage_load,
  output logic [credit_fifo_pkg::data_width-1:0]  stage_data,
  output logic [credit_fifo_pkg::count_width-1:0] items,
  output logic                                    empty,
  output logic                                    full
);

  // Head and tail of the ring inside the flop RAM
  logic [credit_fifo_pkg::addr_width-1:0] wr_ptr;
  logic [credit_fifo_pkg::addr_width-1:0] rd_ptr;

  // Credits that left the RAM while the stall was raised
  logic [credit_fifo_pkg::count_width-1:0] pending;

  // Next value of the registered credit pulse
  logic credit_next;

  //--------------------------------------------------------------------------
  // RAM write side
  //--------------------------------------------------------------------------

  // Every push goes straight into the slot under the write pointer.
  // The sender never pushes without a credit, so a push never meets a full RAM
  assign ram_wr_valid = push_valid;
  assign ram_wr_addr  = wr_ptr;
  assign ram_wr_data  = push_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push_valid) begin
      // Wrap explicitly so the ring is correct for any depth, not only powers of two
      if (int'(wr_ptr) == credit_fifo_pkg::fifo_depth - 1) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // RAM read side and output stage feed
  //--------------------------------------------------------------------------

  // The oldest word is always sitting at the read pointer
  assign ram_rd_addr = rd_ptr;
  assign stage_data  = ram_rd_data;

  // Move a word whenever one is stored and the pop register can take it
  assign stage_load = (items != '0) && stage_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (stage_load) begin
      if (int'(rd_ptr) == credit_fifo_pkg::fifo_depth - 1) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Occupancy
  //--------------------------------------------------------------------------

  // Counts words in the RAM only, the word in the output stage is not included
  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
    end else begin
      case ({push_valid, stage_load})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

  assign empty = (items == '0);
  assign full  = (int'(items) == credit_fifo_pkg::fifo_depth);

  //--------------------------------------------------------------------------
  // Credit return
  //--------------------------------------------------------------------------

  // A credit goes out whenever the stall is low and one is owed,
  // either from this cycle's read or from the pending count
  assign credit_next = !credit_stall && (stage_load || (pending != '0));

  // Pending grows by the read and shrinks by the released pulse.
  // A read and a release in the same cycle leave it unchanged
  always_ff @(posedge clk) begin
    if (rst) begin
      pending     <= '0;
      push_credit <= 1'b0;
    end else begin
      push_credit <= credit_next;
      case ({stage_load, credit_next})
        2'b10:   pending <= pending + 1'b1;
        2'b01:   pending <= pending - 1'b1;
        default: pending <= pending;
      endcase
    end
  end

endmodule : fifo_ctrl_credit

// File: source/credit_sender.sv
// Starts with fifo_depth credits after reset; at most one push and one credit per cycle
`timescale 1ns/1ps

module credit_sender (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  src_valid,
  input  logic [credit_fifo_pkg::data_width-1:0] src_data,
  input  logic                                  push_credit,
  output logic                                  src_ready,
  output logic                                  push_valid,
  output logic [credit_fifo_pkg::data_width-1:0] push_data
);

  // Credits currently held by the source side
  logic [credit_fifo_pkg::count_width-1:0] credit_count;

  //--------------------------------------------------------------------------
  // Push gating
  //--------------------------------------------------------------------------

  // The source may only hand over a word while one credit is left to spend
  assign src_ready = (credit_count != '0);

  // A push is the taken source word, so it is purely combinational
  assign push_valid = src_valid && src_ready;

  // Data rides along with the push strobe unchanged
  assign push_data = src_data;

  //--------------------------------------------------------------------------
  // Credit counter
  //--------------------------------------------------------------------------

  // Each push spends a credit and each returned pulse gives one back.
  // When both land in the same cycle the count stays where it is
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_count <= credit_fifo_pkg::count_width'(credit_fifo_pkg::fifo_depth);
    end else begin
      case ({push_valid, push_credit})
        2'b10: begin
          credit_count <= credit_count - 1'b1;
        end
        2'b01: begin
          credit_count <= credit_count + 1'b1;
        end
        default: begin
          credit_count <= credit_count;
        end
      endcase
    end
  end

endmodule : credit_sender

// File: source/credit_fifo_pkg.sv
// Depth and width are fixed here; addr_width and count_width must be kept in step by hand
package credit_fifo_pkg;

  //--------------------------------------------------------------------------
  // Geometry
  //--------------------------------------------------------------------------

  // Number of RAM entries, which is also the credit the sender starts with
  localparam int fifo_depth = 4;

  // Width of one data word on every path through the link
  localparam int data_width = 8;

  // Address width of the flop RAM for the depth above
  localparam int addr_width = 2;

  // Occupancy, credit and pending counts must be able to hold fifo_depth itself
  localparam int count_width = 3;

  //--------------------------------------------------------------------------
  // Output stage
  //--------------------------------------------------------------------------

  // The pop register is either holding a word or waiting for one
  typedef enum logic {
    out_empty = 1'b0,
    out_full  = 1'b1
  } out_state_t;

endpackage : credit_fifo_pkg
